// File: design/phy_pkg.sv
/*
 * Shared types and default sizes for the DDR3 PHY data path model.
 * Modules take what they need with a wildcard import in their header.
 */

`default_nettype none

package phy_pkg;

    // write serializer state
    typedef enum logic {
        SER_IDLE  = 1'b0, // no burst on the pins
        SER_BURST = 1'b1  // beats being driven
    } ser_state_e;

    // read deserializer state
    typedef enum logic {
        DES_IDLE    = 1'b0, // waiting for a read enable
        DES_CAPTURE = 1'b1  // sampling dq beats
    } des_state_e;

    parameter int DEF_DQ_WIDTH   = 16; // two byte lanes
    parameter int DEF_BURST_LEN  = 4;  // beats per burst
    parameter int DEF_ADDR_WIDTH = 16;
    parameter int DEF_BANK_WIDTH = 3;
    parameter int DEF_RANKS      = 2;  // width of cs_n, cke, odt
    parameter int DEF_WR_DEPTH   = 4;  // write fifo depth in bursts

endpackage

`default_nettype wire

// File: design/phy_cmd_path.sv
/*
 * Command and address registration from the DFI side to the memory pins.
 * Every field reaches its pin one cycle later. Also forms the memory clock.
 */

`timescale 1ns/10ps
`default_nettype none

module phy_cmd_path import phy_pkg::*; #(
    parameter int ADDR_WIDTH = DEF_ADDR_WIDTH,
    parameter int BANK_WIDTH = DEF_BANK_WIDTH,
    parameter int RANKS      = DEF_RANKS
) (
    input  wire                   dfi_clk,
    input  wire                   rst_i,
    input  logic [ADDR_WIDTH-1:0] dfi_address_i,
    input  logic [BANK_WIDTH-1:0] dfi_bank_i,
    input  logic                  dfi_ras_n_i,
    input  logic                  dfi_cas_n_i,
    input  logic                  dfi_we_n_i,
    input  logic [RANKS-1:0]      dfi_cs_n_i,
    input  logic [RANKS-1:0]      dfi_cke_i,
    input  logic [RANKS-1:0]      dfi_odt_i,
    input  logic                  dfi_reset_n_i,
    output logic [ADDR_WIDTH-1:0] ddr_addr_o,
    output logic [BANK_WIDTH-1:0] ddr_ba_o,
    output logic                  ddr_ras_n_o,
    output logic                  ddr_cas_n_o,
    output logic                  ddr_we_n_o,
    output logic [RANKS-1:0]      ddr_cs_n_o,
    output logic [RANKS-1:0]      ddr_cke_o,
    output logic [RANKS-1:0]      ddr_odt_o,
    output logic                  ddr_reset_n_o,
    output logic                  ddr_ck_p_o,
    output logic                  ddr_ck_n_o
);

    always_ff @(posedge dfi_clk) begin
        if (rst_i) begin
            ddr_addr_o    <= '0;
            ddr_ba_o      <= '0;
            ddr_ras_n_o   <= 1'b1;          // nop command while in reset
            ddr_cas_n_o   <= 1'b1;
            ddr_we_n_o    <= 1'b1;
            ddr_cs_n_o    <= '1;            // all ranks deselected
            ddr_cke_o     <= '0;
            ddr_odt_o     <= '0;
            ddr_reset_n_o <= 1'b0;          // hold memory in reset
            ddr_ck_p_o    <= 1'b0;          // clock parked low
        end else begin
            ddr_addr_o    <= dfi_address_i;
            ddr_ba_o      <= dfi_bank_i;
            ddr_ras_n_o   <= dfi_ras_n_i;
            ddr_cas_n_o   <= dfi_cas_n_i;
            ddr_we_n_o    <= dfi_we_n_i;
            ddr_cs_n_o    <= dfi_cs_n_i;
            ddr_cke_o     <= dfi_cke_i;
            ddr_odt_o     <= dfi_odt_i;
            ddr_reset_n_o <= dfi_reset_n_i;
            ddr_ck_p_o    <= ~ddr_ck_p_o;   // free running toggle
        end
    end

    assign ddr_ck_n_o = ~ddr_ck_p_o; // differential partner

endmodule

`default_nettype wire

// File: design/phy_wr_fifo.sv
/*
 * Circular buffer of write bursts between the DFI write port and the serializer.
 * Head is shown combinationally; push and pop may share a cycle.
 */

`timescale 1ns/10ps
`default_nettype none

module phy_wr_fifo import phy_pkg::*; #(
    parameter int DQ_WIDTH  = DEF_DQ_WIDTH,
    parameter int BURST_LEN = DEF_BURST_LEN,
    parameter int WR_DEPTH  = DEF_WR_DEPTH
) (
    input  wire                              dfi_clk,
    input  wire                              rst_i,
    input  logic                             wr_push_i,
    input  logic [BURST_LEN*DQ_WIDTH-1:0]    wr_data_i,
    input  logic [BURST_LEN*DQ_WIDTH/8-1:0]  wr_mask_i,
    input  logic                             wr_pop_i,
    output logic                             wr_ready_o,
    output logic [BURST_LEN*DQ_WIDTH-1:0]    wr_head_data_o,
    output logic [BURST_LEN*DQ_WIDTH/8-1:0]  wr_head_mask_o,
    output logic                             wr_head_valid_o
);

    localparam int DATA_W = BURST_LEN * DQ_WIDTH;
    localparam int MASK_W = BURST_LEN * DQ_WIDTH / 8;
    localparam int PTR_W  = (WR_DEPTH > 1) ? $clog2(WR_DEPTH) : 1;
    localparam int CNT_W  = $clog2(WR_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(WR_DEPTH - 1);

    logic [DATA_W-1:0] data_mem [WR_DEPTH];
    logic [MASK_W-1:0] mask_mem [WR_DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CNT_W-1:0]  count_q;
    logic              push;
    logic              pop;

    assign wr_ready_o      = (count_q != CNT_W'(WR_DEPTH)); // low when full
    assign wr_head_valid_o = (count_q != '0);
    assign push            = wr_push_i & wr_ready_o;       // enable while full is dropped
    assign pop             = wr_pop_i & wr_head_valid_o;

    assign wr_head_data_o = data_mem[rd_ptr_q];
    assign wr_head_mask_o = mask_mem[rd_ptr_q];

    always_ff @(posedge dfi_clk) begin
        if (push) begin
            data_mem[wr_ptr_q] <= wr_data_i;
            mask_mem[wr_ptr_q] <= wr_mask_i;
        end
    end

    always_ff @(posedge dfi_clk) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= (wr_ptr_q == LAST_SLOT) ? '0 : wr_ptr_q + 1'b1; // wrap at depth
            if (pop)  rd_ptr_q <= (rd_ptr_q == LAST_SLOT) ? '0 : rd_ptr_q + 1'b1;
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;     // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/phy_wr_serializer.sv
/*
 * Write serializer. Takes one burst from the write FIFO and drives it onto
 * DQ and DM one beat per cycle, with DQS toggling and the output enables high.
 * The next burst is taken on the last beat so bursts run back to back.
 */

`timescale 1ns/10ps
`default_nettype none

module phy_wr_serializer import phy_pkg::*; #(
    parameter int DQ_WIDTH  = DEF_DQ_WIDTH,
    parameter int BURST_LEN = DEF_BURST_LEN
) (
    input  wire                              dfi_clk,
    input  wire                              rst_i,
    input  logic [BURST_LEN*DQ_WIDTH-1:0]    wr_head_data_i,
    input  logic [BURST_LEN*DQ_WIDTH/8-1:0]  wr_head_mask_i,
    input  logic                             wr_head_valid_i,
    output logic                             wr_pop_o,
    output logic [DQ_WIDTH-1:0]              ddr_dq_o,
    output logic [DQ_WIDTH/8-1:0]            ddr_dm_o,
    output logic                             ddr_dq_oe_o,
    output logic [DQ_WIDTH/8-1:0]            ddr_dqs_p_o,
    output logic [DQ_WIDTH/8-1:0]            ddr_dqs_n_o,
    output logic                             ddr_dqs_oe_o
);

    localparam int DM_WIDTH = DQ_WIDTH / 8;
    localparam int DATA_W   = BURST_LEN * DQ_WIDTH;
    localparam int MASK_W   = BURST_LEN * DM_WIDTH;
    localparam int BEAT_W   = (BURST_LEN > 1) ? $clog2(BURST_LEN) : 1;
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(BURST_LEN - 1);

    ser_state_e        state_q;
    logic [BEAT_W-1:0] beat_cnt_q;
    logic [DATA_W-1:0] data_q;     // held burst, current beat in low bits
    logic [MASK_W-1:0] mask_q;
    logic              last_beat;
    logic              dqs_level;

    assign last_beat = (state_q == SER_BURST) && (beat_cnt_q == LAST_BEAT);
    assign wr_pop_o  = wr_head_valid_i & ((state_q == SER_IDLE) | last_beat); // take next burst

    always_ff @(posedge dfi_clk) begin
        if (rst_i) begin
            state_q    <= SER_IDLE;
            beat_cnt_q <= '0;
        end else if (wr_pop_o) begin
            state_q    <= SER_BURST;    // start or chain a burst
            beat_cnt_q <= '0;
        end else if (last_beat) begin
            state_q    <= SER_IDLE;     // queue ran dry
            beat_cnt_q <= '0;
        end else if (state_q == SER_BURST) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
        end
    end

    // burst shift registers, payload only
    always_ff @(posedge dfi_clk) begin
        if (wr_pop_o) begin
            data_q <= wr_head_data_i;
            mask_q <= wr_head_mask_i;
        end else begin
            data_q <= data_q >> DQ_WIDTH;  // next beat down
            mask_q <= mask_q >> DM_WIDTH;
        end
    end

    assign ddr_dq_o     = data_q[DQ_WIDTH-1:0];
    assign ddr_dm_o     = mask_q[DM_WIDTH-1:0];
    assign ddr_dq_oe_o  = (state_q == SER_BURST);
    assign ddr_dqs_oe_o = (state_q == SER_BURST);   // strobe driven with data

    assign dqs_level   = ddr_dq_oe_o & ~beat_cnt_q[0]; // high on even beats
    assign ddr_dqs_p_o = {DM_WIDTH{dqs_level}};     // one strobe per byte lane
    assign ddr_dqs_n_o = ~ddr_dqs_p_o;

endmodule

`default_nettype wire

// File: design/phy_rd_deserializer.sv
/*
 * Read deserializer. After a read enable, samples BURST_LEN beats of DQ and
 * presents them as one DFI word, beat 0 in the low bits, with a one cycle valid.
 */

`timescale 1ns/10ps
`default_nettype none

module phy_rd_deserializer import phy_pkg::*; #(
    parameter int DQ_WIDTH  = DEF_DQ_WIDTH,
    parameter int BURST_LEN = DEF_BURST_LEN
) (
    input  wire                           dfi_clk,
    input  wire                           rst_i,
    input  logic                          dfi_rddata_en_i,
    input  logic [DQ_WIDTH-1:0]           ddr_dq_i,
    output logic [BURST_LEN*DQ_WIDTH-1:0] dfi_rddata_o,
    output logic                          dfi_rddata_valid_o
);

    localparam int WORD_W = BURST_LEN * DQ_WIDTH;
    localparam int BEAT_W = (BURST_LEN > 1) ? $clog2(BURST_LEN) : 1;
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(BURST_LEN - 1);

    des_state_e        state_q;
    logic [BEAT_W-1:0] beat_cnt_q;
    logic [WORD_W-1:0] asm_q;       // assembly register
    logic [WORD_W-1:0] asm_next;
    logic              last_beat;

    // new beat enters at the top, so beat 0 ends up lowest
    assign asm_next  = WORD_W'({ddr_dq_i, asm_q} >> DQ_WIDTH);
    assign last_beat = (state_q == DES_CAPTURE) && (beat_cnt_q == LAST_BEAT);

    always_ff @(posedge dfi_clk) begin
        if (rst_i) begin
            state_q            <= DES_IDLE;
            beat_cnt_q         <= '0;
            dfi_rddata_valid_o <= 1'b0;
        end else begin
            dfi_rddata_valid_o <= last_beat;     // one cycle after the last sample
            if (dfi_rddata_en_i) begin
                state_q    <= DES_CAPTURE;       // may overlap the last beat
                beat_cnt_q <= '0;
            end else if (last_beat) begin
                state_q    <= DES_IDLE;
                beat_cnt_q <= '0;
            end else if (state_q == DES_CAPTURE) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
            end
        end
    end

    // payload registers
    always_ff @(posedge dfi_clk) begin
        if (state_q == DES_CAPTURE) asm_q <= asm_next;
        if (last_beat) dfi_rddata_o <= asm_next;    // word held while next read gathers
    end

endmodule

`default_nettype wire

// File: design/phy_top.sv
/*
 * Top level of the single clock DDR3 PHY data path model.
 * Sets the sizes and wires the command path, write FIFO, write serializer
 * and read deserializer. Bidirectional pins come as drive, enable and sample.
 */

`timescale 1ns/10ps
`default_nettype none

module phy_top import phy_pkg::*; #(
    parameter int DQ_WIDTH   = DEF_DQ_WIDTH,
    parameter int BURST_LEN  = DEF_BURST_LEN,
    parameter int ADDR_WIDTH = DEF_ADDR_WIDTH,
    parameter int BANK_WIDTH = DEF_BANK_WIDTH,
    parameter int RANKS      = DEF_RANKS,
    parameter int WR_DEPTH   = DEF_WR_DEPTH
) (
    input  wire                              dfi_clk,
    input  wire                              rst_i,
    // dfi command side
    input  logic [ADDR_WIDTH-1:0]            dfi_address_i,
    input  logic [BANK_WIDTH-1:0]            dfi_bank_i,
    input  logic                             dfi_ras_n_i,
    input  logic                             dfi_cas_n_i,
    input  logic                             dfi_we_n_i,
    input  logic [RANKS-1:0]                 dfi_cs_n_i,
    input  logic [RANKS-1:0]                 dfi_cke_i,
    input  logic [RANKS-1:0]                 dfi_odt_i,
    input  logic                             dfi_reset_n_i,
    // dfi write and read data
    input  logic                             dfi_wrdata_en_i,
    input  logic [BURST_LEN*DQ_WIDTH-1:0]    dfi_wrdata_i,
    input  logic [BURST_LEN*DQ_WIDTH/8-1:0]  dfi_wrdata_mask_i,
    output logic                             dfi_wrdata_ready_o,
    input  logic                             dfi_rddata_en_i,
    output logic [BURST_LEN*DQ_WIDTH-1:0]    dfi_rddata_o,
    output logic                             dfi_rddata_valid_o,
    // ddr3 pins
    output logic [ADDR_WIDTH-1:0]            ddr_addr_o,
    output logic [BANK_WIDTH-1:0]            ddr_ba_o,
    output logic                             ddr_ras_n_o,
    output logic                             ddr_cas_n_o,
    output logic                             ddr_we_n_o,
    output logic [RANKS-1:0]                 ddr_cs_n_o,
    output logic [RANKS-1:0]                 ddr_cke_o,
    output logic [RANKS-1:0]                 ddr_odt_o,
    output logic                             ddr_reset_n_o,
    output logic                             ddr_ck_p_o,
    output logic                             ddr_ck_n_o,
    output logic [DQ_WIDTH-1:0]              ddr_dq_o,
    output logic [DQ_WIDTH/8-1:0]            ddr_dm_o,
    output logic                             ddr_dq_oe_o,
    output logic [DQ_WIDTH/8-1:0]            ddr_dqs_p_o,
    output logic [DQ_WIDTH/8-1:0]            ddr_dqs_n_o,
    output logic                             ddr_dqs_oe_o,
    input  logic [DQ_WIDTH-1:0]              ddr_dq_i
);

    logic [BURST_LEN*DQ_WIDTH-1:0]   wr_head_data;  // fifo head to serializer
    logic [BURST_LEN*DQ_WIDTH/8-1:0] wr_head_mask;
    logic                            wr_head_valid;
    logic                            wr_pop;

    phy_cmd_path #(
        .ADDR_WIDTH(ADDR_WIDTH), .BANK_WIDTH(BANK_WIDTH), .RANKS(RANKS)
    ) cmd_path_i (
        .dfi_clk, .rst_i,
        .dfi_address_i, .dfi_bank_i, .dfi_ras_n_i, .dfi_cas_n_i, .dfi_we_n_i,
        .dfi_cs_n_i, .dfi_cke_i, .dfi_odt_i, .dfi_reset_n_i,
        .ddr_addr_o, .ddr_ba_o, .ddr_ras_n_o, .ddr_cas_n_o, .ddr_we_n_o,
        .ddr_cs_n_o, .ddr_cke_o, .ddr_odt_o, .ddr_reset_n_o, .ddr_ck_p_o, .ddr_ck_n_o
    );

    phy_wr_fifo #(
        .DQ_WIDTH(DQ_WIDTH), .BURST_LEN(BURST_LEN), .WR_DEPTH(WR_DEPTH)
    ) wr_fifo_i (
        .dfi_clk, .rst_i,
        .wr_push_i      (dfi_wrdata_en_i),
        .wr_data_i      (dfi_wrdata_i),
        .wr_mask_i      (dfi_wrdata_mask_i),
        .wr_pop_i       (wr_pop),
        .wr_ready_o     (dfi_wrdata_ready_o),
        .wr_head_data_o (wr_head_data),
        .wr_head_mask_o (wr_head_mask),
        .wr_head_valid_o(wr_head_valid)
    );

    phy_wr_serializer #(
        .DQ_WIDTH(DQ_WIDTH), .BURST_LEN(BURST_LEN)
    ) wr_serializer_i (
        .dfi_clk, .rst_i,
        .wr_head_data_i (wr_head_data),
        .wr_head_mask_i (wr_head_mask),
        .wr_head_valid_i(wr_head_valid),
        .wr_pop_o       (wr_pop),
        .ddr_dq_o, .ddr_dm_o, .ddr_dq_oe_o, .ddr_dqs_p_o, .ddr_dqs_n_o, .ddr_dqs_oe_o
    );

    phy_rd_deserializer #(
        .DQ_WIDTH(DQ_WIDTH), .BURST_LEN(BURST_LEN)
    ) rd_deserializer_i (
        .dfi_clk, .rst_i,
        .dfi_rddata_en_i, .ddr_dq_i, .dfi_rddata_o, .dfi_rddata_valid_o
    );

endmodule

`default_nettype wire

// File: tb/phy_asserts.sv
/*
 * Concurrent assertions on the write serializer, attached by bind.
 * Checks the pop handshake, the output enable and whole bursts on the pins.
 */

`timescale 1ns/10ps
`default_nettype none

module phy_asserts import phy_pkg::*; #(
    parameter int BURST_LEN = DEF_BURST_LEN
) (
    input  wire        dfi_clk,
    input  wire        rst_i,
    input  logic       pop_i,
    input  logic       head_valid_i,
    input  logic       dq_oe_i,
    input  ser_state_e state_i
);

    int run_len;    // consecutive cycles with dq driven
    int beats_left; // beats still owed for the bursts taken

    always @(posedge dfi_clk) begin
        if (rst_i) run_len <= 0;
        else run_len <= dq_oe_i ? run_len + 1 : 0;
    end

    always @(posedge dfi_clk) begin
        if (rst_i) beats_left <= 0;
        else beats_left <= beats_left - int'(dq_oe_i) + (pop_i ? BURST_LEN : 0);
    end

    pop_on_boundary: assert property (@(posedge dfi_clk) disable iff (rst_i)
        pop_i |-> (head_valid_i && (!dq_oe_i || run_len % BURST_LEN == BURST_LEN - 1)))
        else $error("wr_pop fired with no valid head or in the middle of a burst");

    oe_in_burst: assert property (@(posedge dfi_clk) disable iff (rst_i)
        (dq_oe_i == (beats_left != 0)) && ((state_i == SER_BURST) == (beats_left != 0)))
        else $error("ddr_dq_oe_o or SER_BURST does not match the beats owed");

    whole_bursts: assert property (@(posedge dfi_clk) disable iff (rst_i)
        $fell(dq_oe_i) |-> (run_len != 0 && run_len % BURST_LEN == 0))
        else $error("write burst ended off a burst boundary");

endmodule

`default_nettype wire

// File: tb/phy_checker.sv
/*
 * Testbench checker for phy_top. Watches the DFI ports and the memory pins on
 * every rising edge and compares them with a model of the PHY timing rules.
 * The top module calls end_test after each test to print that test's result.
 */

`timescale 1ns/10ps
`default_nettype none

module phy_checker import phy_pkg::*; #(
    parameter int DQ_WIDTH   = DEF_DQ_WIDTH,
    parameter int BURST_LEN  = DEF_BURST_LEN,
    parameter int ADDR_WIDTH = DEF_ADDR_WIDTH,
    parameter int BANK_WIDTH = DEF_BANK_WIDTH,
    parameter int RANKS      = DEF_RANKS
) (
    input  wire                             dfi_clk,
    input  wire                             rst_i,
    input  logic [ADDR_WIDTH-1:0]           dfi_address_i, ddr_addr_o,
    input  logic [BANK_WIDTH-1:0]           dfi_bank_i, ddr_ba_o,
    input  logic                            dfi_ras_n_i, dfi_cas_n_i, dfi_we_n_i, dfi_reset_n_i,
    input  logic                            ddr_ras_n_o, ddr_cas_n_o, ddr_we_n_o, ddr_reset_n_o,
    input  logic [RANKS-1:0]                dfi_cs_n_i, dfi_cke_i, dfi_odt_i,
    input  logic [RANKS-1:0]                ddr_cs_n_o, ddr_cke_o, ddr_odt_o,
    input  logic                            ddr_ck_p_o, ddr_ck_n_o,
    input  logic                            dfi_wrdata_en_i, dfi_wrdata_ready_o,
    input  logic [BURST_LEN*DQ_WIDTH-1:0]   dfi_wrdata_i, dfi_rddata_o,
    input  logic [BURST_LEN*DQ_WIDTH/8-1:0] dfi_wrdata_mask_i,
    input  logic [DQ_WIDTH-1:0]             ddr_dq_o, ddr_dq_i,
    input  logic [DQ_WIDTH/8-1:0]           ddr_dm_o, ddr_dqs_p_o, ddr_dqs_n_o,
    input  logic                            ddr_dq_oe_o, ddr_dqs_oe_o,
    input  logic                            dfi_rddata_en_i, dfi_rddata_valid_o,
    output int                              wr_pending_o, rd_pending_o,
    output int                              tests_run_o, tests_failed_o, errors_o
);

    localparam int DM_WIDTH = DQ_WIDTH / 8;
    localparam int DATA_W   = BURST_LEN * DQ_WIDTH;
    localparam int MASK_W   = BURST_LEN * DM_WIDTH;
    localparam int CMD_W    = ADDR_WIDTH + BANK_WIDTH + 3 * RANKS + 4;

    logic [DATA_W-1:0] wr_data_q [$];   // accepted bursts not yet on the pins
    logic [MASK_W-1:0] wr_mask_q [$];
    logic [DATA_W-1:0] rd_word_q [$];   // gathered read words oldest first
    longint            rd_due_q [$];    // cycle when each word must be valid
    logic [DATA_W-1:0] cur_data, cap_word;
    logic [MASK_W-1:0] cur_mask;
    logic [CMD_W-1:0]  cmd_in, cmd_pin, cmd_d;
    longint            cyc, cap_start;
    bit                seen_clk, rst_d, ck_p_d, cap_active, held_seen;
    int                beat, test_err;

    assign cmd_in  = {dfi_address_i, dfi_bank_i, dfi_ras_n_i, dfi_cas_n_i, dfi_we_n_i,
                      dfi_cs_n_i, dfi_cke_i, dfi_odt_i, dfi_reset_n_i};
    assign cmd_pin = {ddr_addr_o, ddr_ba_o, ddr_ras_n_o, ddr_cas_n_o, ddr_we_n_o,
                      ddr_cs_n_o, ddr_cke_o, ddr_odt_o, ddr_reset_n_o};

    task automatic flag(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        test_err++;
        errors_o++;
    endtask

    task automatic end_test(input string name, input bit need_full);
        if (need_full && !held_seen) flag("dfi_wrdata_ready_o never dropped under a write stream");
        tests_run_o++;
        if (test_err == 0) begin
            $display("test %0d %s: ok", tests_run_o, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run_o, name, test_err);
            tests_failed_o++;
        end
        test_err  = 0;
        held_seen = 0;
    endtask

    always @(posedge dfi_clk) begin
        cyc++;
        if (seen_clk && rst_d) begin    // outputs still show the reset state
            if ({ddr_cs_n_o, ddr_cke_o, ddr_odt_o, ddr_reset_n_o, ddr_ck_p_o}
                    !== {{RANKS{1'b1}}, {(2 * RANKS + 2){1'b0}}})
                flag("command pins not inactive during reset");
            if (ddr_dq_oe_o !== 1'b0 || dfi_rddata_valid_o !== 1'b0 || dfi_wrdata_ready_o !== 1'b1)
                flag("data path outputs wrong during reset");
        end
        if (seen_clk && !rst_d) begin
            if (cmd_pin !== cmd_d)
                flag($sformatf("command pins %h, expected %h", cmd_pin, cmd_d));
            if (ddr_ck_p_o === ck_p_d) flag("ddr_ck_p_o did not toggle");
            if (ddr_dq_oe_o === 1'b1) begin
                if (wr_data_q.size() == 0) begin
                    flag("write beat on the pins with no burst accepted");
                end else begin
                    cur_data = wr_data_q[0];
                    cur_mask = wr_mask_q[0];
                    if (ddr_dq_o !== cur_data[beat*DQ_WIDTH +: DQ_WIDTH]
                            || ddr_dm_o !== cur_mask[beat*DM_WIDTH +: DM_WIDTH])
                        flag($sformatf("write beat %0d dq %h dm %h, expected %h %h", beat,
                            ddr_dq_o, ddr_dm_o, cur_data[beat*DQ_WIDTH +: DQ_WIDTH],
                            cur_mask[beat*DM_WIDTH +: DM_WIDTH]));
                    if (ddr_dqs_p_o !== {DM_WIDTH{~beat[0]}})
                        flag($sformatf("dqs %b on write beat %0d", ddr_dqs_p_o, beat));
                    beat++;
                    if (beat == BURST_LEN) begin    // burst complete so retire it
                        beat = 0;
                        void'(wr_data_q.pop_front());
                        void'(wr_mask_q.pop_front());
                    end
                end
            end else if (beat != 0) begin
                flag($sformatf("write burst cut short after %0d beats", beat));
                beat = 0;
            end
            if (rd_due_q.size() > 0 && rd_due_q[0] == cyc) begin
                if (dfi_rddata_valid_o !== 1'b1)
                    flag("read word not valid when due");
                else if (dfi_rddata_o !== rd_word_q[0])
                    flag($sformatf("read word %h, expected %h", dfi_rddata_o, rd_word_q[0]));
                void'(rd_due_q.pop_front());
                void'(rd_word_q.pop_front());
            end else if (dfi_rddata_valid_o !== 1'b0) begin
                flag("dfi_rddata_valid_o high with no read due");
            end
        end
        if (seen_clk && ddr_ck_n_o !== ~ddr_ck_p_o) flag("ddr_ck_n_o not the complement of ck_p");
        if (seen_clk && ddr_dqs_n_o !== ~ddr_dqs_p_o)
            flag("ddr_dqs_n_o not the complement of dqs_p");
        if (seen_clk && ddr_dqs_oe_o !== ddr_dq_oe_o) flag("ddr_dqs_oe_o differs from ddr_dq_oe_o");
        if (!rst_i && dfi_wrdata_en_i === 1'b1) begin
            if (dfi_wrdata_ready_o === 1'b1) begin  // accepted this edge
                wr_data_q.push_back(dfi_wrdata_i);
                wr_mask_q.push_back(dfi_wrdata_mask_i);
            end else begin
                held_seen = 1;                      // fifo full so the source holds
            end
        end
        if (!rst_i && cap_active) begin             // beats T+1 .. T+BURST_LEN
            cap_word[int'(cyc - cap_start - 1)*DQ_WIDTH +: DQ_WIDTH] = ddr_dq_i;
            if (cyc - cap_start == BURST_LEN) begin
                rd_word_q.push_back(cap_word);
                rd_due_q.push_back(cyc + 1);
                cap_active = 0;
            end
        end
        if (!rst_i && dfi_rddata_en_i === 1'b1) begin
            cap_active = 1;
            cap_start  = cyc;
            cap_word   = '0;
        end
        cmd_d        = cmd_in;
        ck_p_d       = ddr_ck_p_o;
        rst_d        = rst_i;
        seen_clk     = 1;
        wr_pending_o = wr_data_q.size();
        rd_pending_o = rd_due_q.size() + int'(cap_active);
    end

endmodule

`default_nettype wire

// File: tb/tb_phy_top.sv
/*
 * Testbench for phy_top. Drives reset, random commands, write bursts and reads
 * on the falling edge from an LFSR and answers reads with random DQ beats.
 * phy_checker does the comparing; this module prints the summary.
 */

`timescale 1ns/10ps
`default_nettype none

module tb_phy_top import phy_pkg::*; ();

    localparam int DQ_WIDTH   = DEF_DQ_WIDTH;
    localparam int BURST_LEN  = DEF_BURST_LEN;
    localparam int ADDR_WIDTH = DEF_ADDR_WIDTH;
    localparam int BANK_WIDTH = DEF_BANK_WIDTH;
    localparam int RANKS      = DEF_RANKS;
    localparam int WR_DEPTH   = DEF_WR_DEPTH;
    localparam int DATA_W     = BURST_LEN * DQ_WIDTH;
    localparam int MASK_W     = DATA_W / 8;
    localparam int WAIT_LIMIT = 200;    // cycles allowed for any single wait

    logic                  dfi_clk, rst_i;
    logic [ADDR_WIDTH-1:0] dfi_address_i, ddr_addr_o;
    logic [BANK_WIDTH-1:0] dfi_bank_i, ddr_ba_o;
    logic                  dfi_ras_n_i, dfi_cas_n_i, dfi_we_n_i, dfi_reset_n_i;
    logic                  ddr_ras_n_o, ddr_cas_n_o, ddr_we_n_o, ddr_reset_n_o;
    logic [RANKS-1:0]      dfi_cs_n_i, dfi_cke_i, dfi_odt_i, ddr_cs_n_o, ddr_cke_o, ddr_odt_o;
    logic                  ddr_ck_p_o, ddr_ck_n_o;
    logic                  dfi_wrdata_en_i, dfi_wrdata_ready_o, dfi_rddata_en_i, dfi_rddata_valid_o;
    logic [DATA_W-1:0]     dfi_wrdata_i, dfi_rddata_o;
    logic [MASK_W-1:0]     dfi_wrdata_mask_i;
    logic [DQ_WIDTH-1:0]   ddr_dq_o, ddr_dq_i;
    logic [DQ_WIDTH/8-1:0] ddr_dm_o, ddr_dqs_p_o, ddr_dqs_n_o;
    logic                  ddr_dq_oe_o, ddr_dqs_oe_o;
    int                    wr_pending_o, rd_pending_o, tests_run_o, tests_failed_o, errors_o;
    logic [31:0]           lfsr_q = 32'h7a0;
    bit                    timed_out;

    phy_top #(
        .DQ_WIDTH(DQ_WIDTH), .BURST_LEN(BURST_LEN), .ADDR_WIDTH(ADDR_WIDTH),
        .BANK_WIDTH(BANK_WIDTH), .RANKS(RANKS), .WR_DEPTH(WR_DEPTH)
    ) phy_top_i (.*);

    phy_checker #(
        .DQ_WIDTH(DQ_WIDTH), .BURST_LEN(BURST_LEN), .ADDR_WIDTH(ADDR_WIDTH),
        .BANK_WIDTH(BANK_WIDTH), .RANKS(RANKS)
    ) checker_i (.*);

    bind phy_wr_serializer phy_asserts #(.BURST_LEN(BURST_LEN)) asserts_i (
        .dfi_clk(dfi_clk), .rst_i(rst_i), .pop_i(wr_pop_o), .head_valid_i(wr_head_valid_i),
        .dq_oe_i(ddr_dq_oe_o), .state_i(state_q)
    );

    initial begin
        dfi_clk = 1'b0;
        forever #4 dfi_clk = ~dfi_clk;  // 8 ns period
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [127:0] rand_bits(input int n);
        logic [127:0] r;
        logic         fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[126:0], fb};
        end
        return r;
    endfunction

    task automatic note_timeout(input string what);
        $display("timeout: no %s within %0d cycles", what, WAIT_LIMIT);
        timed_out = 1'b1;
    endtask

    task automatic drive_cmd();
        {dfi_address_i, dfi_bank_i} = (ADDR_WIDTH + BANK_WIDTH)'(rand_bits(ADDR_WIDTH + BANK_WIDTH));
        {dfi_ras_n_i, dfi_cas_n_i, dfi_we_n_i, dfi_reset_n_i} = 4'(rand_bits(4));
        {dfi_cs_n_i, dfi_cke_i, dfi_odt_i} = (3 * RANKS)'(rand_bits(3 * RANKS));
    endtask

    task automatic send_write();
        int waits;
        waits             = 0;
        dfi_wrdata_en_i   = 1'b1;
        dfi_wrdata_i      = DATA_W'(rand_bits(DATA_W));
        dfi_wrdata_mask_i = MASK_W'(rand_bits(MASK_W));
        while (dfi_wrdata_ready_o !== 1'b1 && !timed_out) begin  // hold data while full
            @(negedge dfi_clk);
            waits++;
            if (waits > WAIT_LIMIT) note_timeout("rise of dfi_wrdata_ready_o");
        end
        @(negedge dfi_clk);             // taken on the edge just passed
        dfi_wrdata_en_i = 1'b0;
    endtask

    task automatic wait_idle();
        int waits;
        waits = 0;
        while ((wr_pending_o != 0 || rd_pending_o != 0) && !timed_out) begin
            @(negedge dfi_clk);
            waits++;
            if (waits > WAIT_LIMIT) note_timeout("drain of pending bursts");
        end
        repeat (2) @(negedge dfi_clk);
    endtask

    task automatic run_writes(input int count, input int max_gap);
        for (int n = 0; n < count && !timed_out; n++) begin
            send_write();
            repeat (int'(rand_bits(2)) % (max_gap + 1)) @(negedge dfi_clk);
        end
        wait_idle();
    endtask

    // memory side responder, a fresh dq beat every cycle
    task automatic respond_beat();
        ddr_dq_i = DQ_WIDTH'(rand_bits(DQ_WIDTH));
    endtask

    task automatic run_reads(input int count);
        int gap;
        for (int n = 0; n < count && !timed_out; n++) begin
            gap = (n < 4) ? BURST_LEN : BURST_LEN + int'(rand_bits(2)); // first ones tight
            dfi_rddata_en_i = 1'b1;
            for (int c = 0; c < gap; c++) begin
                respond_beat();
                @(negedge dfi_clk);
                dfi_rddata_en_i = 1'b0;
            end
        end
        repeat (BURST_LEN) begin        // tail of the last burst
            respond_beat();
            @(negedge dfi_clk);
        end
        ddr_dq_i = '0;
        wait_idle();
    endtask

    initial begin
        timed_out         = 1'b0;
        rst_i             = 1'b1;
        dfi_address_i     = '0;
        dfi_bank_i        = '0;
        dfi_ras_n_i       = 1'b1;
        dfi_cas_n_i       = 1'b1;
        dfi_we_n_i        = 1'b1;
        dfi_cs_n_i        = '1;
        dfi_cke_i         = '0;
        dfi_odt_i         = '0;
        dfi_reset_n_i     = 1'b0;
        dfi_wrdata_en_i   = 1'b0;
        dfi_wrdata_i      = '0;
        dfi_wrdata_mask_i = '0;
        dfi_rddata_en_i   = 1'b0;
        ddr_dq_i          = '0;
        repeat (2) @(posedge dfi_clk);  // reset over two cycles
        @(negedge dfi_clk);
        rst_i = 1'b0;
        @(negedge dfi_clk);
        checker_i.end_test("reset values", 1'b0);
        for (int n = 0; n < 200; n++) begin
            drive_cmd();
            @(negedge dfi_clk);
        end
        @(negedge dfi_clk);
        checker_i.end_test("command path", 1'b0);
        run_writes(40, 3);
        checker_i.end_test("write data", 1'b0);
        run_writes(24, 0);
        checker_i.end_test("write back-pressure", 1'b1);
        run_reads(30);
        checker_i.end_test("read data", 1'b0);
        $display("tests %0d, failed %0d, errors %0d", tests_run_o, tests_failed_o, errors_o);
        if (timed_out || tests_failed_o != 0) begin
            $display("TEST FAIL");
        end else begin
            $display("TEST PASS");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
design/phy_pkg.sv
design/phy_cmd_path.sv
design/phy_wr_fifo.sv
design/phy_wr_serializer.sv
design/phy_rd_deserializer.sv
design/phy_top.sv
tb/phy_asserts.sv
tb/phy_checker.sv
tb/tb_phy_top.sv

// File: run.sh
#!/bin/sh
# builds the PHY model and testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_phy_top \
    -f project.f -o sim_phy
./obj_dir/sim_phy | tee sim.log

if grep -q "^TEST PASS$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
